// ==== sim.f ====
+incdir+bench
logic/mul16_pkg.sv
logic/cla_adder.sv
logic/sync_fifo.sv
logic/quadrant_mult.sv
logic/product_sum.sv
logic/mul16_apb_regs.sv
logic/mul16_top.sv
bench/mul16_tb.sv

// ==== bench/mul16_patterns.txt ====
// operands {b, a}   expected product, both hex, one pair per line
// b is the upper half of the first column
00000000 00000000
00010001 00000001
FFFFFFFF FFFE0001
00FFFF00 00FE0100
00030002 00000006
56781234 06260060
0001FFFF 0000FFFF
80008000 40000000
FF0000FF 00FE0100
01000100 00010000
0010ABCD 000ABCD0
0002FFFF 0001FFFE
00FF00FF 0000FE01
00038001 00018003

// ==== bench/mul16_tb_tasks.svh ====
// APB transfer tasks, xorshift generator and compare tasks; included inside the mul16 testbench
`ifndef MUL16_TB_TASKS_SVH
`define MUL16_TB_TASKS_SVH

// Setup phase, then access phase held until pready or the timeout
task automatic apb_transfer(input logic [ADDR_W-1:0] addr, input logic write,
                            input logic [31:0] wdata, output product_t rdata,
                            output logic slverr, output int waits);
  int   cycles;
  logic done;
  cycles = 0;
  done   = 1'b0;
  rdata  = '0;
  slverr = 1'b0;
  @(negedge clk);
  psel       = 1'b1;
  req.paddr  = addr;
  req.pwrite = write;
  req.pwdata = wdata;
  @(negedge clk);
  penable = 1'b1;
  while (!done && cycles < TIMEOUT_CYCLES) begin
    @(posedge clk);
    if (pready) begin
      done   = 1'b1;
      rdata  = prdata;
      slverr = pslverr;
    end else begin
      cycles++;
    end
  end
  @(negedge clk);
  psel    = 1'b0;
  penable = 1'b0;
  waits   = cycles;
  if (!done) begin
    errors++;
    $display("APB %s of address %0d timed out waiting for pready",
             write ? "write" : "read", addr);
  end
endtask

task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                         output logic slverr);
  product_t unused_data;
  int       unused_waits;
  apb_transfer(addr, 1'b1, data, unused_data, slverr, unused_waits);
endtask

task automatic apb_read(input logic [ADDR_W-1:0] addr, output product_t data,
                        output logic slverr, output int waits);
  apb_transfer(addr, 1'b0, '0, data, slverr, waits);
endtask

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  x ^= x << 13;
  x ^= x >> 17;
  x ^= x << 5;
  return x;
endfunction

task automatic check_product(input string name, input product_t expected,
                             input product_t actual);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("ERROR %s: expected %h, actual %h", name, expected, actual);
  end
endtask

task automatic check_status(input string name, input logic [1:0] expected,
                            input logic [1:0] actual);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("ERROR %s: expected %b, actual %b", name, expected, actual);
  end
endtask

task automatic check_slverr(input string name, input logic expected, input logic actual);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("ERROR %s: expected pslverr %b, actual %b", name, expected, actual);
  end
endtask

`endif

// ==== bench/mul16_tb.sv ====
// Testbench for the APB multiplier; runs pattern, random, back-pressure and error checks
`timescale 1ns/1ps
`default_nettype none

module mul16_tb import mul16_pkg::*;;

  localparam int          PERIOD         = 20;
  localparam int          TIMEOUT_CYCLES = 100;
  localparam int          FIFO_DEPTH     = 4;
  localparam int          PATTERN_COUNT  = 14;
  localparam int          RANDOM_COUNT   = 200;
  localparam logic [31:0] SEED           = 32'h88f7_ace5;

  logic     clk;
  logic     arst_n;
  logic     psel;
  logic     penable;
  apb_req_t req;
  product_t prdata;
  logic     pready;
  logic     pslverr;

  int errors;
  int checks;

  // Two words per line: operand pair, then expected product
  logic [31:0] pattern_mem [2*PATTERN_COUNT];

  mul16_top #(.FIFO_DEPTH(FIFO_DEPTH)) mul16_top_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .req     (req),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  `include "mul16_tb_tasks.svh"

  always #(PERIOD/2) clk = ~clk;

  task automatic multiply_and_check(input string name, input logic [15:0] a,
                                    input logic [15:0] b, input product_t expected);
    product_t result;
    logic     slverr;
    int       waits;
    apb_write(REG_OPERANDS, {b, a}, slverr);
    check_slverr({name, " write"}, 1'b0, slverr);
    apb_read(REG_RESULT, result, slverr, waits);
    check_slverr({name, " read"}, 1'b0, slverr);
    check_product(name, expected, result);
  endtask

  // Polls REG_STATUS until it shows the expected flags or the polls run out
  task automatic wait_for_status(input string name, input logic [1:0] expected);
    product_t rd;
    logic     slverr;
    int       waits;
    int       polls;
    polls = 0;
    rd    = '1;
    while (rd[1:0] !== expected && polls < TIMEOUT_CYCLES) begin
      apb_read(REG_STATUS, rd, slverr, waits);
      polls++;
    end
    check_status(name, expected, rd[1:0]);
  endtask

  initial begin : stimulus
    product_t    rd;
    logic        slverr;
    int          waits;
    logic [15:0] a;
    logic [15:0] b;
    logic [31:0] state;
    product_t    expected_q[$];
    product_t    file_product;
    clk     = 1'b0;
    arst_n  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    req     = '0;
    errors  = 0;
    checks  = 0;
    $readmemh("bench/mul16_patterns.txt", pattern_mem);
    repeat (2) @(negedge clk);
    arst_n = 1'b1;

    apb_read(REG_STATUS, rd, slverr, waits);
    check_status("status after reset", 2'b10, rd[1:0]);
    check_slverr("status read", 1'b0, slverr);

    // Bad accesses must flag pslverr and leave the FIFOs alone
    apb_write(REG_RESULT, 32'hdead_beef, slverr);
    check_slverr("write to result", 1'b1, slverr);
    apb_read(REG_OPERANDS, rd, slverr, waits);
    check_slverr("read of operands", 1'b1, slverr);
    apb_read(4'd12, rd, slverr, waits);
    check_slverr("read of address 12", 1'b1, slverr);
    apb_write(4'd12, 32'h0001_0001, slverr);
    check_slverr("write to address 12", 1'b1, slverr);
    apb_read(REG_STATUS, rd, slverr, waits);
    check_status("status after bad accesses", 2'b10, rd[1:0]);

    for (int i = 0; i < PATTERN_COUNT; i++) begin
      a            = pattern_mem[2*i][15:0];
      b            = pattern_mem[2*i][31:16];
      file_product = pattern_mem[2*i+1];
      check_product($sformatf("pattern %0d file vs a*b", i), 32'(a) * 32'(b), file_product);
      multiply_and_check($sformatf("pattern %0d", i), a, b, file_product);
    end

    state = SEED;
    for (int i = 0; i < RANDOM_COUNT; i++) begin
      if (i == 0) begin
        a = 16'h0000;
        b = 16'h0000;
      end else if (i == 1) begin
        a = 16'hffff;
        b = 16'hffff;
      end else if (i == 2) begin
        a = 16'hff00;
        b = 16'h00ff;
      end else begin
        state = xorshift32(state);
        a     = state[15:0];
        b     = state[31:16];
      end
      multiply_and_check($sformatf("random %0d", i), a, b, 32'(a) * 32'(b));
    end

    // Fill both FIFOs, then drain part way and add the remaining writes
    state = xorshift32(state);
    for (int i = 0; i < 2*FIFO_DEPTH + 3; i++) begin
      if (i == FIFO_DEPTH*2) begin
        wait_for_status("status with operand FIFO full", 2'b01);
        for (int j = 0; j < FIFO_DEPTH; j++) begin
          apb_read(REG_RESULT, rd, slverr, waits);
          check_product($sformatf("ordered result %0d", j), expected_q.pop_front(), rd);
        end
      end
      state = xorshift32(state);
      a     = state[15:0];
      b     = state[31:16];
      expected_q.push_back(32'(a) * 32'(b));
      apb_write(REG_OPERANDS, {b, a}, slverr);
      check_slverr($sformatf("burst write %0d", i), 1'b0, slverr);
    end
    for (int j = FIFO_DEPTH; j < 2*FIFO_DEPTH + 3; j++) begin
      apb_read(REG_RESULT, rd, slverr, waits);
      check_product($sformatf("ordered result %0d", j), expected_q.pop_front(), rd);
    end
    wait_for_status("status after draining", 2'b10);

    // Read issued while the only operand is still in the pipeline
    apb_write(REG_OPERANDS, {16'h00c8, 16'h3039}, slverr);
    apb_read(REG_RESULT, rd, slverr, waits);
    check_product("stalled read", 32'h3039 * 32'h00c8, rd);
    if (waits == 0) begin
      errors++;
      $display("Result read completed before the pipeline could produce the product");
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/mul16_top.sv ====
// Top level of the APB multiplier; instantiate with FIFO_DEPTH to size both FIFOs
`timescale 1ns/1ps
`default_nettype none

module mul16_top import mul16_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     psel,
  input  logic     penable,
  input  apb_req_t req,
  output product_t prdata,
  output logic     pready,
  output logic     pslverr
);

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic           op_push;
  operand_pair_t  op_data;
  logic           op_full;
  logic           op_empty;
  operand_pair_t  op_head;
  logic           op_pop;
  logic           res_empty;
  product_t       res_head;
  logic           res_pop;
  logic [CNT_W-1:0] res_count;
  logic           q_valid;
  quad_products_t quads;
  logic           p_valid;
  product_t       product;
  logic [CNT_W:0] occupancy;
  logic           room;

  mul16_apb_regs apb_regs_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .psel      (psel),
    .penable   (penable),
    .req       (req),
    .op_full   (op_full),
    .op_push   (op_push),
    .op_data   (op_data),
    .res_empty (res_empty),
    .res_head  (res_head),
    .res_pop   (res_pop),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

  sync_fifo #(.DEPTH(FIFO_DEPTH), .data_t(operand_pair_t)) operand_fifo (
    .clk    (clk),
    .arst_n (arst_n),
    .push   (op_push),
    .wdata  (op_data),
    .pop    (op_pop),
    .rdata  (op_head),
    .full   (op_full),
    .empty  (op_empty),
    .count  ()
  );

  // Reserve a result slot for every item issued, so the pipeline never stalls
  assign occupancy = {1'b0, res_count} + (CNT_W + 1)'(q_valid) + (CNT_W + 1)'(p_valid);
  assign room      = occupancy < (CNT_W + 1)'(FIFO_DEPTH);
  assign op_pop    = !op_empty && room;

  quadrant_mult quadrant_mult_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (op_pop),
    .operands  (op_head),
    .out_valid (q_valid),
    .quads     (quads)
  );

  product_sum product_sum_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (q_valid),
    .quads     (quads),
    .out_valid (p_valid),
    .product   (product)
  );

  sync_fifo #(.DEPTH(FIFO_DEPTH), .data_t(product_t)) result_fifo (
    .clk    (clk),
    .arst_n (arst_n),
    .push   (p_valid),
    .wdata  (product),
    .pop    (res_pop),
    .rdata  (res_head),
    .full   (),
    .empty  (res_empty),
    .count  (res_count)
  );

endmodule

`default_nettype wire

// ==== logic/mul16_apb_regs.sv ====
// APB slave of the multiplier; pushes operand pairs, pops results and reports bad accesses
`timescale 1ns/1ps
`default_nettype none

module mul16_apb_regs import mul16_pkg::*; (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          psel,
  input  logic          penable,
  input  apb_req_t      req,
  input  logic          op_full,
  output logic          op_push,
  output operand_pair_t op_data,
  input  logic          res_empty,
  input  product_t      res_head,
  output logic          res_pop,
  output product_t      prdata,
  output logic          pready,
  output logic          pslverr
);

  logic      access;
  reg_addr_e addr;
  product_t  status;

  assign access  = psel && penable;
  assign addr    = reg_addr_e'(req.paddr);
  assign op_data = operand_pair_t'(req.pwdata);
  assign status  = {{(PROD_W - 2){1'b0}}, res_empty, op_full};

  // Operand and result accesses wait on the FIFO flags while the rest complete at once
  always_comb begin
    op_push = 1'b0;
    res_pop = 1'b0;
    pready  = 1'b0;
    pslverr = 1'b0;
    prdata  = '0;
    if (access) begin
      case (addr)
        REG_OPERANDS: begin
          if (req.pwrite) begin
            pready  = !op_full;
            op_push = !op_full;
          end else begin
            pready  = 1'b1;
            pslverr = 1'b1;
          end
        end
        REG_RESULT: begin
          if (!req.pwrite) begin
            pready  = !res_empty;
            res_pop = !res_empty;
            prdata  = res_head;
          end else begin
            pready  = 1'b1;
            pslverr = 1'b1;
          end
        end
        REG_STATUS: begin
          pready = 1'b1;
          if (!req.pwrite) begin
            prdata = status;
          end else begin
            pslverr = 1'b1;
          end
        end
        default: begin
          pready  = 1'b1;
          pslverr = 1'b1;
        end
      endcase
    end
  end

  // Host must hold a stalled transfer steady until pready
  a_stall_stable: assert property (@(posedge clk) disable iff (!arst_n)
    access && !pready |=> psel && penable && $stable(req))
    else $error("APB request changed during wait state");

endmodule

`default_nettype wire

// ==== logic/product_sum.sv ====
// Second pipeline stage; aligns the quadrant products, adds them and registers the product
`timescale 1ns/1ps
`default_nettype none

module product_sum import mul16_pkg::*; (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           in_valid,
  input  quad_products_t quads,
  output logic           out_valid,
  output product_t       product
);

  product_t hhll;
  product_t lh_shifted;
  product_t hl_shifted;
  product_t partial;
  product_t total;

  // hh and ll do not overlap, so they share one operand
  assign hhll       = {quads.hh, quads.ll};
  assign lh_shifted = {{HALF_W{1'b0}}, quads.lh, {HALF_W{1'b0}}};
  assign hl_shifted = {{HALF_W{1'b0}}, quads.hl, {HALF_W{1'b0}}};

  cla_adder #(.WIDTH(PROD_W)) add_lh (
    .a   (hhll),
    .b   (lh_shifted),
    .sum (partial)
  );

  cla_adder #(.WIDTH(PROD_W)) add_hl (
    .a   (partial),
    .b   (hl_shifted),
    .sum (total)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      product <= total;
    end
  end

  a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(out_valid))
    else $error("product valid is unknown");

endmodule

`default_nettype wire

// ==== logic/quadrant_mult.sv ====
// First pipeline stage; forms the four 8 x 8 quadrant products and registers them
`timescale 1ns/1ps
`default_nettype none

module quadrant_mult import mul16_pkg::*; (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           in_valid,
  input  operand_pair_t  operands,
  output logic           out_valid,
  output quad_products_t quads
);

  logic [HALF_W-1:0]   mx  [4];
  logic [HALF_W-1:0]   my  [4];
  logic [2*HALF_W-1:0] acc [4][HALF_W+1];

  // Quadrant order ll, lh, hl, hh
  assign mx[0] = operands.a[HALF_W-1:0];
  assign my[0] = operands.b[HALF_W-1:0];
  assign mx[1] = operands.a[HALF_W-1:0];
  assign my[1] = operands.b[OP_W-1:HALF_W];
  assign mx[2] = operands.a[OP_W-1:HALF_W];
  assign my[2] = operands.b[HALF_W-1:0];
  assign mx[3] = operands.a[OP_W-1:HALF_W];
  assign my[3] = operands.b[OP_W-1:HALF_W];

  for (genvar q = 0; q < 4; q++) begin : g_quad
    assign acc[q][0] = '0;
    // One row per multiplier bit, each adds the shifted partial product
    for (genvar r = 0; r < HALF_W; r++) begin : g_row
      assign acc[q][r+1] = acc[q][r]
                         + ({{HALF_W{1'b0}}, mx[q] & {HALF_W{my[q][r]}}} << r);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      quads.ll <= acc[0][HALF_W];
      quads.lh <= acc[1][HALF_W];
      quads.hl <= acc[2][HALF_W];
      quads.hh <= acc[3][HALF_W];
    end
  end

endmodule

`default_nettype wire

// ==== logic/sync_fifo.sv ====
// Synchronous FIFO of any entry type; set DEPTH and data_t, head is read combinationally
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int  DEPTH  = 4,
  parameter type data_t = logic
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       push,
  input  data_t                      wdata,
  input  logic                       pop,
  output data_t                      rdata,
  output logic                       full,
  output logic                       empty,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  data_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  // Pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  assign rdata   = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
    full |-> !push)
    else $error("push into full FIFO");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
    empty |-> !pop)
    else $error("pop from empty FIFO");

endmodule

`default_nettype wire

// ==== logic/cla_adder.sv ====
// Carry-lookahead adder in 4-bit groups; WIDTH a multiple of 4, no carry in or out
`timescale 1ns/1ps
`default_nettype none

module cla_adder #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  output logic [WIDTH-1:0] sum
);

  localparam int NG = WIDTH / 4;

  logic [WIDTH-1:0] p;
  logic [WIDTH-1:0] g;
  logic [WIDTH-1:0] c;
  logic [NG-1:0]    gp;
  logic [NG-1:0]    gg;
  logic [NG-1:0]    gc;

  if (WIDTH % 4 != 0) begin : g_width_check
    $error("cla_adder WIDTH must be a multiple of 4");
  end

  assign p = a ^ b;
  assign g = a & b;

  for (genvar k = 0; k < NG; k++) begin : g_group
    assign gp[k] = &p[4*k +: 4];
    assign gg[k] = g[4*k+3]
                 | (p[4*k+3] & g[4*k+2])
                 | (p[4*k+3] & p[4*k+2] & g[4*k+1])
                 | (p[4*k+3] & p[4*k+2] & p[4*k+1] & g[4*k]);

    // Carries inside the group from its lookahead carry
    assign c[4*k]   = gc[k];
    assign c[4*k+1] = g[4*k] | (p[4*k] & gc[k]);
    assign c[4*k+2] = g[4*k+1] | (p[4*k+1] & g[4*k]) | (p[4*k+1] & p[4*k] & gc[k]);
    assign c[4*k+3] = g[4*k+2] | (p[4*k+2] & g[4*k+1])
                    | (p[4*k+2] & p[4*k+1] & g[4*k])
                    | (p[4*k+2] & p[4*k+1] & p[4*k] & gc[k]);
  end

  // Group carries flattened, each an OR of generate terms through later propagates
  always_comb begin : group_lookahead
    logic term;
    logic carry;
    for (int k = 0; k < NG; k++) begin
      carry = 1'b0;
      for (int j = 0; j < k; j++) begin
        term = gg[j];
        for (int m = j + 1; m < k; m++) begin
          term = term & gp[m];
        end
        carry = carry | term;
      end
      gc[k] = carry;
    end
  end

  assign sum = p ^ c;

endmodule

`default_nettype wire

// ==== logic/mul16_pkg.sv ====
// Shared widths, APB register map and bus types for the 16 x 16 multiplier; import into each block
`default_nettype none

package mul16_pkg;

  localparam int OP_W   = 16;
  localparam int HALF_W = 8;
  localparam int PROD_W = 32;
  localparam int ADDR_W = 4;

  // Operand b sits in the upper half of the write data
  typedef struct packed {
    logic [OP_W-1:0] b;
    logic [OP_W-1:0] a;
  } operand_pair_t;

  typedef struct packed {
    logic [2*HALF_W-1:0] hh;
    logic [2*HALF_W-1:0] hl;
    logic [2*HALF_W-1:0] lh;
    logic [2*HALF_W-1:0] ll;
  } quad_products_t;

  typedef logic [PROD_W-1:0] product_t;

  // Held stable by the host while psel is high
  typedef struct packed {
    logic [ADDR_W-1:0] paddr;
    logic              pwrite;
    logic [2*OP_W-1:0] pwdata;
  } apb_req_t;

  typedef enum logic [ADDR_W-1:0] {
    REG_OPERANDS = 4'd0,
    REG_RESULT   = 4'd4,
    REG_STATUS   = 4'd8
  } reg_addr_e;

endpackage

`default_nettype wire
